//--- src.f
verilog/spi_flash_pkg.sv
verilog/spi_byte_link.sv
verilog/flash_cmd_ctrl.sv
verilog/flash_mem.sv
verilog/access_log_fifo.sv
verilog/spi_flash_emu.sv
tests/spi_flash_emu_assert.sv
tests/tb_spi_flash_emu.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the SPI flash emulator testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--timescale 1ns/1ps \
	--top-module tb_spi_flash_emu \
	-Mdir obj_dir \
	-f src.f

./obj_dir/Vtb_spi_flash_emu 2>&1 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

//--- tests/tb_spi_flash_emu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_flash_emu;
	localparam int MEM_ADDR_W = 12;
	localparam int LOG_DEPTH = 4;
	localparam int MEM_SIZE = 1 << MEM_ADDR_W;
	// sclk half period in clk cycles
	localparam int HALF = 6;
	// idle time after cs_n rises, covers the log push
	localparam int GAP = 12;
	// ten transactions of at most 20 bytes, 96 clk per byte, plus the ram load
	localparam int MAX_XFER_BYTES = 10 * 20;
	localparam int TIMEOUT_CYCLES = MEM_SIZE + MAX_XFER_BYTES * 96 + 2000;

	logic clk;
	logic rst_n;
	logic sclk;
	logic cs_n;
	logic mosi;
	logic miso;
	logic load_en;
	spi_flash_pkg::flash_addr_t load_addr;
	spi_flash_pkg::byte_t load_data;
	logic log_pop;
	logic log_valid;
	spi_flash_pkg::log_rec_t log_out;
	logic [7:0] log_dropped;
	logic critical;

	// local copy of the ram contents
	spi_flash_pkg::byte_t model_mem [MEM_SIZE];
	// bytes of one transaction, both directions
	spi_flash_pkg::byte_t mosi_bytes [$];
	spi_flash_pkg::byte_t miso_bytes [$];
	// critical seen at the first bit of each byte
	logic crit_at_byte [$];
	// expected log fifo contents and drops
	logic [31:0] exp_addr [$];
	logic [31:0] exp_len [$];
	int exp_dropped;
	logic [31:0] rng;
	int errors;
	int tests_failed;
	int cycles;

	spi_flash_emu #(
		.MEM_ADDR_W(MEM_ADDR_W),
		.LOG_DEPTH(LOG_DEPTH)
	) DUT (
		.clk(clk),
		.rst_n(rst_n),
		.sclk(sclk),
		.cs_n(cs_n),
		.mosi(mosi),
		.miso(miso),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.log_pop(log_pop),
		.log_valid(log_valid),
		.log_out(log_out),
		.log_dropped(log_dropped),
		.critical(critical)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// run limit
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout: tests still running after %0d clock cycles", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// inputs change 1 ns after the rising edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic check_val(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("CHECK FAILED time=%0t %s expected=0x%0h actual=0x%0h",
				$time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic report_test(input int num, input string name, input int errs_before);
		if (errors == errs_before)
		begin
			$display("test %0d %s: passed", num, name);
		end
		else
		begin
			$display("test %0d %s: failed with %0d errors", num, name, errors - errs_before);
			tests_failed++;
		end
	endtask

	// fill every ram byte with a random value through the load port
	task automatic load_ram();
		for (int a = 0; a < MEM_SIZE; a++)
		begin
			rng = xorshift32(rng);
			model_mem[a] = rng[7:0];
			load_en = 1'b1;
			load_addr = 24'(a);
			load_data = rng[7:0];
			wait_cycles(1);
		end
		load_en = 1'b0;
	endtask

	// mode 0 master, mosi set while sclk low, miso taken just before the rise
	task automatic transfer_bytes();
		logic [7:0] rx_b;
		int b;
		miso_bytes.delete();
		crit_at_byte.delete();
		cs_n = 1'b0;
		foreach (mosi_bytes[k])
		begin
			rx_b = 8'h00;
			for (b = 7; b >= 0; b--)
			begin
				mosi = mosi_bytes[k][b];
				wait_cycles(HALF);
				if (b == 7)
				begin
					crit_at_byte.push_back(critical);
				end
				rx_b = {rx_b[6:0], miso};
				sclk = 1'b1;
				wait_cycles(HALF);
				sclk = 1'b0;
			end
			miso_bytes.push_back(rx_b);
		end
		wait_cycles(HALF);
		cs_n = 1'b1;
		wait_cycles(GAP);
	endtask

	// 0x03 read, data byte i must be the ram byte at addr + i with wrap
	task automatic read_flash(input spi_flash_pkg::flash_addr_t addr, input int len);
		int idx;
		mosi_bytes.delete();
		mosi_bytes.push_back(8'h03);
		mosi_bytes.push_back(addr[23:16]);
		mosi_bytes.push_back(addr[15:8]);
		mosi_bytes.push_back(addr[7:0]);
		for (int i = 0; i < len; i++)
		begin
			mosi_bytes.push_back(8'h00);
		end
		transfer_bytes();
		check_val("critical before command", 32'(0), 32'(crit_at_byte[0]));
		for (int i = 0; i < len; i++)
		begin
			idx = (int'(addr) + i) % MEM_SIZE;
			check_val($sformatf("miso data[%0d]", i), 32'(model_mem[idx]),
				32'(miso_bytes[4 + i]));
			check_val($sformatf("critical data[%0d]", i), 32'(1), 32'(crit_at_byte[4 + i]));
		end
		// fifo model, a full fifo drops the new entry
		if (exp_addr.size() < LOG_DEPTH)
		begin
			exp_addr.push_back(32'(addr));
			exp_len.push_back(32'(len));
		end
		else
		begin
			exp_dropped++;
		end
	endtask

	task automatic pop_and_check();
		check_val("log_valid", 32'(1), 32'(log_valid));
		check_val("log_out.addr", exp_addr[0], 32'(log_out.addr));
		check_val("log_out.len", exp_len[0], 32'(log_out.len));
		exp_addr.delete(0);
		exp_len.delete(0);
		log_pop = 1'b1;
		wait_cycles(1);
		log_pop = 1'b0;
		wait_cycles(1);
	endtask

	task automatic drain_log();
		while (exp_addr.size() > 0)
		begin
			pop_and_check();
		end
		check_val("log_valid after drain", 32'(0), 32'(log_valid));
	endtask

	initial
	begin
		int errs;
		int len;
		int k;
		spi_flash_pkg::flash_addr_t addr;
		spi_flash_pkg::byte_t cmd;
		rst_n = 1'b0;
		sclk = 1'b0;
		cs_n = 1'b1;
		mosi = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		log_pop = 1'b0;
		rng = 32'd58881;
		errors = 0;
		tests_failed = 0;
		exp_dropped = 0;
		wait_cycles(3);
		rst_n = 1'b1;
		wait_cycles(2);

		// idle outputs straight out of reset
		errs = errors;
		check_val("critical", 32'(0), 32'(critical));
		check_val("log_valid", 32'(0), 32'(log_valid));
		check_val("miso", 32'(1), 32'(miso));
		check_val("log_dropped", 32'(0), 32'(log_dropped));
		report_test(1, "reset state", errs);

		load_ram();

		errs = errors;
		rng = xorshift32(rng);
		addr = rng[23:0];
		len = 1 + int'(rng[27:24]);
		read_flash(addr, len);
		report_test(2, "random read", errs);

		// start a few bytes below the ram top so the read wraps to 0
		errs = errors;
		rng = xorshift32(rng);
		k = 1 + int'(rng[1:0]);
		addr = (rng[23:0] & ~24'(MEM_SIZE - 1)) | 24'(MEM_SIZE - k);
		len = k + 1 + int'(rng[30:28]);
		read_flash(addr, len);
		report_test(3, "wrapping read", errs);

		// any other opcode gets 0xff and no lock
		errs = errors;
		rng = xorshift32(rng);
		cmd = rng[7:0];
		if (cmd == spi_flash_pkg::CMD_READ)
		begin
			cmd = 8'h9F;
		end
		len = 1 + int'(rng[11:8]);
		mosi_bytes.delete();
		mosi_bytes.push_back(cmd);
		for (int i = 0; i < len + 3; i++)
		begin
			mosi_bytes.push_back(rng[23:16]);
		end
		transfer_bytes();
		foreach (miso_bytes[j])
		begin
			check_val($sformatf("miso[%0d]", j), 32'(8'hFF), 32'(miso_bytes[j]));
			check_val($sformatf("critical[%0d]", j), 32'(0), 32'(crit_at_byte[j]));
		end
		report_test(4, "non-read command", errs);

		// three entries by now, in transaction order
		errs = errors;
		rng = xorshift32(rng);
		read_flash(rng[23:0], 1 + int'(rng[27:24]));
		drain_log();
		report_test(5, "log order and pop", errs);

		errs = errors;
		for (int t = 0; t < 6; t++)
		begin
			rng = xorshift32(rng);
			read_flash(rng[23:0], 1 + int'(rng[27:24]));
		end
		check_val("log_dropped", 32'(exp_dropped), 32'(log_dropped));
		drain_log();
		report_test(6, "log overflow", errs);

		$display("summary: 6 tests, %0d failed, %0d check errors", tests_failed, errors);
		if (errors == 0)
		begin
			$display("STATUS: PASS");
		end
		else
		begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/spi_flash_emu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_emu_assert (
	input wire                             clk,
	input wire                             rst_n,
	input wire                             cs_active,
	input wire                             critical,
	input wire spi_flash_pkg::mem_rd_req_t rd_req,
	input wire spi_flash_pkg::mem_rd_rsp_t rd_rsp,
	input wire                             log_valid,
	input wire                             log_pop
);
	// critical clears one cycle after the synchronized cs_n rise
	crit_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(!cs_active && !$past(cs_active)) |-> !critical)
		else $error("critical high while cs_n is high");

	// fixed two cycle read latency
	rsp_follows: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rd_req.strobe, 2) |-> rd_rsp.valid)
		else $error("no ram response two cycles after a read strobe");

	// entries only leave through a pop
	log_kept: assert property (@(posedge clk) disable iff (!rst_n)
		(!log_valid && $past(log_valid)) |-> $past(log_pop))
		else $error("log_valid fell without log_pop");

endmodule

bind spi_flash_emu spi_flash_emu_assert u_protocol_assert (
	.clk(clk),
	.rst_n(rst_n),
	.cs_active(cs_active),
	.critical(critical),
	.rd_req(rd_req),
	.rd_rsp(rd_rsp),
	.log_valid(log_valid),
	.log_pop(log_pop)
);

`default_nettype wire

//--- verilog/spi_flash_emu.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_emu #(
	parameter int MEM_ADDR_W = 12,
	parameter int LOG_DEPTH = 4
) (
	input  wire                             clk,
	input  wire                             rst_n,
	// spi bus
	input  wire                             sclk,
	input  wire                             cs_n,
	input  wire                             mosi,
	output logic                            miso,
	// host load port
	input  wire                             load_en,
	input  wire spi_flash_pkg::flash_addr_t load_addr,
	input  wire spi_flash_pkg::byte_t       load_data,
	// access log
	input  wire                             log_pop,
	output logic                            log_valid,
	output spi_flash_pkg::log_rec_t         log_out,
	output logic [7:0]                      log_dropped,
	// memory lock request
	output logic                            critical
);
	spi_flash_pkg::spi_rx_t rx;
	logic cs_active;
	spi_flash_pkg::byte_t tx_byte;
	spi_flash_pkg::mem_rd_req_t rd_req;
	spi_flash_pkg::mem_rd_rsp_t rd_rsp;
	logic log_push;
	spi_flash_pkg::log_rec_t log_rec;

	// pin side, bytes in and out
	spi_byte_link u_link (
		.clk(clk),
		.rst_n(rst_n),
		.sclk(sclk),
		.cs_n(cs_n),
		.mosi(mosi),
		.miso(miso),
		.rx(rx),
		.cs_active(cs_active),
		.tx_byte(tx_byte)
	);

	// read command decode and fetch
	flash_cmd_ctrl u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.rx(rx),
		.cs_active(cs_active),
		.tx_byte(tx_byte),
		.rd_req(rd_req),
		.rd_rsp(rd_rsp),
		.critical(critical),
		.log_push(log_push),
		.log_rec(log_rec)
	);

	flash_mem #(
		.MEM_ADDR_W(MEM_ADDR_W)
	) u_mem (
		.clk(clk),
		.rst_n(rst_n),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.rd_req(rd_req),
		.rd_rsp(rd_rsp)
	);

	access_log_fifo #(
		.LOG_DEPTH(LOG_DEPTH)
	) u_log (
		.clk(clk),
		.rst_n(rst_n),
		.push(log_push),
		.push_rec(log_rec),
		.pop(log_pop),
		.log_valid(log_valid),
		.log_out(log_out),
		.dropped(log_dropped)
	);

endmodule

`default_nettype wire

//--- verilog/access_log_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module access_log_fifo #(
	parameter int LOG_DEPTH = 4
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          push,
	input  wire spi_flash_pkg::log_rec_t push_rec,
	input  wire                          pop,
	output logic                         log_valid,
	output spi_flash_pkg::log_rec_t      log_out,
	output logic [7:0]                   dropped
);
	localparam int PTR_W = (LOG_DEPTH > 1) ? $clog2(LOG_DEPTH) : 1;
	localparam int CNT_W = $clog2(LOG_DEPTH + 1);

	spi_flash_pkg::log_rec_t entries [LOG_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;
	logic do_push;
	logic do_pop;

	// pointer step with wrap, depth need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		next_ptr = (ptr == PTR_W'(LOG_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full = (count == CNT_W'(LOG_DEPTH));
	assign log_valid = (count != '0);
	// full is judged before any pop in the same cycle
	assign do_push = push & ~full;
	assign do_pop = pop & log_valid;
	assign log_out = entries[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_push)
		begin
			entries[wr_ptr] <= push_rec;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			dropped <= 8'd0;
		end
		else
		begin
			if (do_push)
			begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop)
			begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// lost entries, sticky and saturating
			if (push && full && (dropped != 8'hFF))
			begin
				dropped <= dropped + 8'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/flash_mem.sv
`timescale 1ns/1ps
`default_nettype none

module flash_mem #(
	parameter int MEM_ADDR_W = 12
) (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire                             load_en,
	input  wire spi_flash_pkg::flash_addr_t load_addr,
	input  wire spi_flash_pkg::byte_t       load_data,
	input  wire spi_flash_pkg::mem_rd_req_t rd_req,
	output spi_flash_pkg::mem_rd_rsp_t      rd_rsp
);
	localparam int MEM_SIZE = 1 << MEM_ADDR_W;

	spi_flash_pkg::byte_t mem [MEM_SIZE];
	// flash addresses wrap on the ram size
	logic [MEM_ADDR_W-1:0] wr_idx;
	logic [MEM_ADDR_W-1:0] rd_idx;
	// read pipeline, one data and one valid per stage
	spi_flash_pkg::byte_t rd_data_s1;
	spi_flash_pkg::byte_t rd_data_s2;
	logic rd_valid_s1;
	logic rd_valid_s2;

	assign wr_idx = load_addr[MEM_ADDR_W-1:0];
	assign rd_idx = rd_req.addr[MEM_ADDR_W-1:0];
	assign rd_rsp = '{data: rd_data_s2, valid: rd_valid_s2};

	// host load port, only used while no read is running
	always_ff @(posedge clk)
	begin
		if (load_en)
		begin
			mem[wr_idx] <= load_data;
		end
	end

	// array read and output register
	always_ff @(posedge clk)
	begin
		rd_data_s1 <= mem[rd_idx];
		rd_data_s2 <= rd_data_s1;
	end

	// valid follows the strobe two cycles later
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_valid_s1 <= 1'b0;
			rd_valid_s2 <= 1'b0;
		end
		else
		begin
			rd_valid_s1 <= rd_req.strobe;
			rd_valid_s2 <= rd_valid_s1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/flash_cmd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module flash_cmd_ctrl (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire spi_flash_pkg::spi_rx_t rx,
	input  wire                         cs_active,
	output spi_flash_pkg::byte_t        tx_byte,
	output spi_flash_pkg::mem_rd_req_t  rd_req,
	input  wire spi_flash_pkg::mem_rd_rsp_t rd_rsp,
	output logic                        critical,
	output logic                        log_push,
	output spi_flash_pkg::log_rec_t     log_rec
);
	spi_flash_pkg::ctrl_state_t state;
	// next ram address to fetch
	spi_flash_pkg::flash_addr_t rd_addr;
	// first address of the read, kept for the log
	spi_flash_pkg::flash_addr_t start_addr;
	// full address once the low byte arrives
	spi_flash_pkg::flash_addr_t lo_addr;
	spi_flash_pkg::log_len_t data_len;
	logic cmd_strobe;
	logic rd_fire;

	assign cmd_strobe = rx.strobe & rx.cmd;
	assign lo_addr = {rd_addr[23:8], rx.data};

	// fetch on the low address byte, then once per streamed byte
	assign rd_fire = rx.strobe & ~rx.cmd &
		((state == spi_flash_pkg::ADDR_LO) || (state == spi_flash_pkg::STREAM));

	// the first fetch uses the address byte still on the bus
	assign rd_req = '{
		addr: (state == spi_flash_pkg::ADDR_LO) ? lo_addr : rd_addr,
		strobe: rd_fire
	};

	assign log_rec = '{addr: start_addr, len: data_len};

	// command FSM
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= spi_flash_pkg::IDLE;
			critical <= 1'b0;
			log_push <= 1'b0;
		end
		else
		begin
			log_push <= 1'b0;
			if (!cs_active)
			begin
				// end of transaction, log only reads that reached data
				if (state == spi_flash_pkg::STREAM)
				begin
					log_push <= 1'b1;
				end
				state <= spi_flash_pkg::IDLE;
				critical <= 1'b0;
			end
			else if (cmd_strobe)
			begin
				if (rx.data == spi_flash_pkg::CMD_READ)
				begin
					// hold the memory for the whole read
					state <= spi_flash_pkg::ADDR_HI;
					critical <= 1'b1;
				end
				else
				begin
					state <= spi_flash_pkg::IGNORE;
				end
			end
			else if (rx.strobe)
			begin
				case (state)
					spi_flash_pkg::ADDR_HI: state <= spi_flash_pkg::ADDR_MID;
					spi_flash_pkg::ADDR_MID: state <= spi_flash_pkg::ADDR_LO;
					spi_flash_pkg::ADDR_LO: state <= spi_flash_pkg::STREAM;
					default: state <= state;
				endcase
			end
		end
	end

	// reply byte, 0xff unless a read response has landed
	always_ff @(posedge clk)
	begin
		if (!rst_n || !cs_active)
		begin
			tx_byte <= 8'hFF;
		end
		else if (rd_rsp.valid && (state == spi_flash_pkg::STREAM))
		begin
			tx_byte <= rd_rsp.data;
		end
	end

	// address assembly and data byte count
	always_ff @(posedge clk)
	begin
		if (cmd_strobe)
		begin
			data_len <= '0;
		end
		else if (rx.strobe)
		begin
			case (state)
				spi_flash_pkg::ADDR_HI: rd_addr[23:16] <= rx.data;
				spi_flash_pkg::ADDR_MID: rd_addr[15:8] <= rx.data;
				spi_flash_pkg::ADDR_LO:
				begin
					start_addr <= lo_addr;
					rd_addr <= lo_addr + 24'd1;
				end
				spi_flash_pkg::STREAM:
				begin
					rd_addr <= rd_addr + 24'd1;
					// every clocked data byte counts, held at 255
					if (data_len != 8'hFF)
					begin
						data_len <= data_len + 8'd1;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/spi_byte_link.sv
`timescale 1ns/1ps
`default_nettype none

module spi_byte_link (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    sclk,
	input  wire                    cs_n,
	input  wire                    mosi,
	output logic                   miso,
	output spi_flash_pkg::spi_rx_t rx,
	output logic                   cs_active,
	input  wire spi_flash_pkg::byte_t tx_byte
);
	// two flops per pin, bit 1 is the synchronized value
	logic [1:0] sclk_sync;
	logic [1:0] cs_sync;
	logic [1:0] mosi_sync;
	// last synchronized sclk, for edge detect
	logic sclk_prev;
	// registered edge pulses
	logic sclk_rise;
	logic sclk_fall;
	// mosi aligned with sclk_rise
	logic mosi_bit;
	// receive side
	logic [2:0] bit_cnt;
	logic [6:0] rx_shift;
	logic first_byte;
	spi_flash_pkg::byte_t rx_data;
	logic rx_cmd;
	logic rx_strobe;
	// transmit side
	logic tx_pending;
	spi_flash_pkg::byte_t tx_shift;

	assign rx = '{data: rx_data, cmd: rx_cmd, strobe: rx_strobe};
	assign cs_active = ~cs_sync[1];

	// pin synchronizers, idle bus is sclk low and cs_n high
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			sclk_sync <= 2'b00;
			cs_sync <= 2'b11;
			mosi_sync <= 2'b00;
			sclk_prev <= 1'b0;
			sclk_rise <= 1'b0;
			sclk_fall <= 1'b0;
		end
		else
		begin
			sclk_sync <= {sclk_sync[0], sclk};
			cs_sync <= {cs_sync[0], cs_n};
			mosi_sync <= {mosi_sync[0], mosi};
			sclk_prev <= sclk_sync[1];
			// edges only count while selected
			sclk_rise <= sclk_sync[1] & ~sclk_prev & ~cs_sync[1];
			sclk_fall <= ~sclk_sync[1] & sclk_prev & ~cs_sync[1];
		end
	end

	// bit counter and byte strobe
	always_ff @(posedge clk)
	begin
		if (!rst_n || cs_sync[1])
		begin
			bit_cnt <= 3'd0;
			first_byte <= 1'b1;
			rx_cmd <= 1'b0;
			rx_strobe <= 1'b0;
		end
		else
		begin
			rx_strobe <= 1'b0;
			if (sclk_rise)
			begin
				bit_cnt <= bit_cnt + 3'd1;
				// eighth bit closes the byte
				if (bit_cnt == 3'd7)
				begin
					rx_strobe <= 1'b1;
					rx_cmd <= first_byte;
					first_byte <= 1'b0;
				end
			end
		end
	end

	// receive shifter, mode 0 samples on rising sclk, msb first
	always_ff @(posedge clk)
	begin
		mosi_bit <= mosi_sync[1];
		if (sclk_rise)
		begin
			rx_shift <= {rx_shift[5:0], mosi_bit};
			if (bit_cnt == 3'd7)
			begin
				rx_data <= {rx_shift, mosi_bit};
			end
		end
	end

	// transmit shifter, miso changes on falling sclk
	// the byte boundary arms a load, the reply is copied on the first
	// falling edge after it so the ram data has time to arrive
	always_ff @(posedge clk)
	begin
		if (!rst_n || cs_sync[1])
		begin
			miso <= 1'b1;
			tx_shift <= 8'hFF;
			tx_pending <= 1'b0;
		end
		else
		begin
			if (rx_strobe)
			begin
				tx_pending <= 1'b1;
			end
			if (sclk_fall)
			begin
				if (tx_pending)
				begin
					// msb of the new byte goes out right away
					miso <= tx_byte[7];
					tx_shift <= {tx_byte[6:0], 1'b1};
					tx_pending <= 1'b0;
				end
				else
				begin
					miso <= tx_shift[7];
					tx_shift <= {tx_shift[6:0], 1'b1};
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/spi_flash_pkg.sv
`default_nettype none

package spi_flash_pkg;

	// one data byte on the spi and ram paths
	typedef logic [7:0] byte_t;

	// flash address as sent by the master, three bytes msb first
	typedef logic [23:0] flash_addr_t;

	// data bytes per read, saturates at 255
	typedef logic [7:0] log_len_t;

	// the only command that is served
	localparam byte_t CMD_READ = 8'h03;

	// command controller states
	typedef enum logic [2:0] {
		IDLE,
		ADDR_HI,
		ADDR_MID,
		ADDR_LO,
		STREAM,
		IGNORE
	} ctrl_state_t;

	// received byte from the spi slave
	// cmd marks the first byte after cs_n falls
	typedef struct packed {
		byte_t data;
		logic  cmd;
		logic  strobe;
	} spi_rx_t;

	// ram read request
	typedef struct packed {
		flash_addr_t addr;
		logic        strobe;
	} mem_rd_req_t;

	// ram read response, two cycles after the request
	typedef struct packed {
		byte_t data;
		logic  valid;
	} mem_rd_rsp_t;

	// one completed read in the access log
	typedef struct packed {
		flash_addr_t addr;
		log_len_t    len;
	} log_rec_t;

endpackage

`default_nettype wire
